/* design/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    // ########################################
    // widths
    // ########################################

    // data path and address width of the core
    localparam int xlen = 32;
    // five bits select one of the 32 architectural registers
    localparam int reg_addr_w = 5;
    localparam int imm_src_w = 2;
    localparam int alu_ctrl_w = 2;

    // ########################################
    // datapath select encodings
    // ########################################

    // immediate format chosen by the extender
    localparam logic [imm_src_w-1:0] imm_src_i = 2'd0;
    localparam logic [imm_src_w-1:0] imm_src_s = 2'd1;
    localparam logic [imm_src_w-1:0] imm_src_b = 2'd2;

    // operation performed by the alu
    localparam logic [alu_ctrl_w-1:0] alu_add = 2'd0;
    localparam logic [alu_ctrl_w-1:0] alu_sub = 2'd1;
    localparam logic [alu_ctrl_w-1:0] alu_and = 2'd2;
    localparam logic [alu_ctrl_w-1:0] alu_or  = 2'd3;

    // second alu operand comes from rs2 or from the extended immediate
    localparam logic alu_src_reg     = 1'b0;
    localparam logic alu_src_ext_imm = 1'b1;

    // value written back to the register file
    localparam logic res_src_alu       = 1'b0;
    localparam logic res_src_read_data = 1'b1;

    // ########################################
    // instruction fields
    // ########################################

    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;

    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_or  = 3'b110;

    // funct7 bit 5 (instr bit 30) turns add into sub for register ops
    localparam int funct7_sub_bit = 5;

    // bit positions inside the 4-bit alu flag vector
    localparam int flag_n = 3;
    localparam int flag_z = 2;
    localparam int flag_c = 1;
    localparam int flag_v = 0;

endpackage

`default_nettype wire

/* design/regfile.sv */
`default_nettype none

module regfile (
    input  logic                             clk,
    input  logic [riscv_pkg::reg_addr_w-1:0] addr1,
    input  logic [riscv_pkg::reg_addr_w-1:0] addr2,
    input  logic [riscv_pkg::reg_addr_w-1:0] addr3,
    input  logic [riscv_pkg::xlen-1:0]       wd3,
    input  logic                             we,
    output logic [riscv_pkg::xlen-1:0]       rd1,
    output logic [riscv_pkg::xlen-1:0]       rd2
);
    import riscv_pkg::*;

    // one entry per architectural register
    // entry 0 is never written, reads of x0 are forced to zero below
    logic [xlen-1:0] regs [2**reg_addr_w];

    // write port, takes effect at the edge that retires the instruction
    always_ff @(posedge clk) begin
        if (we && (addr3 != '0)) begin
            regs[addr3] <= wd3;
        end
    end

    // ########################################
    // read ports
    // ########################################

    // both reads are combinational so an instruction sees
    // the values left by the previous one in the same cycle
    assign rd1 = (addr1 == '0) ? '0 : regs[addr1];
    assign rd2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

/* design/imm_extend.sv */
`default_nettype none

module imm_extend (
    input  logic [riscv_pkg::xlen-1:0]      instr,
    input  logic [riscv_pkg::imm_src_w-1:0] imm_src,
    output logic [riscv_pkg::xlen-1:0]      ext_imm
);
    import riscv_pkg::*;

    // the sign bit of every immediate format sits in instr bit 31
    logic sign;

    assign sign = instr[xlen-1];

    always_comb begin
        case (imm_src)
            // i format, imm[11:0] lies in one piece at the top of the word
            imm_src_i: begin
                ext_imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            // s format, the low five bits take the place of rd
            imm_src_s: begin
                ext_imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            // b format is a halfword offset
            // imm[11] hides in instr bit 7 and imm[0] is always zero
            imm_src_b: begin
                ext_imm = {{(xlen-12){sign}}, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            // no instruction of the subset uses the fourth encoding
            default: begin
                ext_imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu (
    input  logic [riscv_pkg::xlen-1:0]       a,
    input  logic [riscv_pkg::xlen-1:0]       b,
    input  logic [riscv_pkg::alu_ctrl_w-1:0] alu_ctrl,
    output logic [riscv_pkg::xlen-1:0]       result,
    output logic [3:0]                       flags
);
    import riscv_pkg::*;

    logic            is_sub;
    logic            is_arith;
    logic [xlen-1:0] b_eff;
    logic [xlen:0]   sum;
    logic            overflow;

    // ########################################
    // adder shared by add and sub
    // ########################################

    // sub is a + ~b + 1, so one adder with a carry in covers both
    assign is_sub   = (alu_ctrl == alu_sub);
    assign is_arith = (alu_ctrl == alu_add) || is_sub;
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, is_sub};

    // signed overflow when both operands share a sign the sum does not have
    assign overflow = (a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != a[xlen-1]);

    always_comb begin
        case (alu_ctrl)
            alu_add: result = sum[xlen-1:0];
            alu_sub: result = sum[xlen-1:0];
            alu_and: result = a & b;
            alu_or:  result = a | b;
            default: result = sum[xlen-1:0];
        endcase
    end

    // ########################################
    // flags
    // ########################################

    // carry after sub means no borrow, as on most flag based machines
    // c and v carry no meaning for the logic operations and read zero there
    always_comb begin
        flags         = '0;
        flags[flag_n] = result[xlen-1];
        flags[flag_z] = (result == '0);
        flags[flag_c] = is_arith & sum[xlen];
        flags[flag_v] = is_arith & overflow;
    end

endmodule

`default_nettype wire

/* design/control_unit.sv */
`default_nettype none

module control_unit (
    input  logic [riscv_pkg::xlen-1:0]       instr,
    input  logic                             alu_zero,
    output logic                             reg_we,
    output logic                             mem_we,
    output logic [riscv_pkg::imm_src_w-1:0]  imm_src,
    output logic [riscv_pkg::alu_ctrl_w-1:0] alu_ctrl,
    output logic                             alu_src,
    output logic                             result_src,
    output logic                             pc_src
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_sub;
    logic       branch;
    logic       arith;
    logic       is_op;

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    // funct7 occupies instr[31:25]
    assign funct7_sub = instr[25 + funct7_sub_bit];

    // ########################################
    // main decoder
    // ########################################

    always_comb begin
        // defaults describe an instruction that changes nothing
        // but the pc, which is also what unknown opcodes get
        reg_we     = 1'b0;
        mem_we     = 1'b0;
        imm_src    = imm_src_i;
        alu_src    = alu_src_reg;
        result_src = res_src_alu;
        branch     = 1'b0;
        arith      = 1'b0;
        case (opcode)
            opcode_load: begin
                reg_we     = 1'b1;
                alu_src    = alu_src_ext_imm;
                result_src = res_src_read_data;
            end
            opcode_store: begin
                mem_we  = 1'b1;
                imm_src = imm_src_s;
                alu_src = alu_src_ext_imm;
            end
            // beq compares rs1 and rs2 by subtracting them
            opcode_branch: begin
                imm_src = imm_src_b;
                branch  = 1'b1;
            end
            opcode_op_imm: begin
                reg_we  = 1'b1;
                alu_src = alu_src_ext_imm;
                arith   = 1'b1;
            end
            opcode_op: begin
                reg_we = 1'b1;
                arith  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ########################################
    // alu decoder
    // ########################################

    // addi has no sub form, the funct7 bit is part of its immediate
    assign is_op = (opcode == opcode_op);

    always_comb begin
        alu_ctrl = alu_add;
        if (branch) begin
            alu_ctrl = alu_sub;
        end else if (arith) begin
            case (funct3)
                funct3_add: alu_ctrl = (is_op && funct7_sub) ? alu_sub : alu_add;
                funct3_and: alu_ctrl = alu_and;
                funct3_or:  alu_ctrl = alu_or;
                default:    alu_ctrl = alu_add;
            endcase
        end
    end

    // the branch is taken when rs1 - rs2 came out zero
    assign pc_src = branch & alu_zero;

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

module datapath (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [riscv_pkg::xlen-1:0]       instr,
    input  logic [riscv_pkg::xlen-1:0]       read_data,
    input  logic                             reg_we,
    input  logic [riscv_pkg::imm_src_w-1:0]  imm_src,
    input  logic [riscv_pkg::alu_ctrl_w-1:0] alu_ctrl,
    input  logic                             alu_src,
    input  logic                             result_src,
    input  logic                             pc_src,
    output logic [riscv_pkg::xlen-1:0]       pc,
    output logic [riscv_pkg::xlen-1:0]       alu_out,
    output logic [riscv_pkg::xlen-1:0]       write_data,
    output logic                             alu_zero
);
    import riscv_pkg::*;

    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] pc_plus_off;
    logic [xlen-1:0] ext_imm;
    logic [xlen-1:0] srca;
    logic [xlen-1:0] srcb;
    logic [xlen-1:0] reg_wr_data;
    logic [3:0]      alu_flags;

    // ########################################
    // program counter
    // ########################################

    // branch offsets are relative to the branch itself
    assign pc_plus_4   = pc + xlen'(4);
    assign pc_plus_off = pc + ext_imm;
    assign pc_next     = pc_src ? pc_plus_off : pc_plus_4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // ########################################
    // register file, extender and alu
    // ########################################

    // rs2 goes straight out as store data
    regfile u_regfile (
        .clk   (clk),
        .addr1 (instr[19:15]),
        .addr2 (instr[24:20]),
        .addr3 (instr[11:7]),
        .wd3   (reg_wr_data),
        .we    (reg_we),
        .rd1   (srca),
        .rd2   (write_data)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .ext_imm (ext_imm)
    );

    assign srcb = (alu_src == alu_src_ext_imm) ? ext_imm : write_data;

    alu u_alu (
        .a        (srca),
        .b        (srcb),
        .alu_ctrl (alu_ctrl),
        .result   (alu_out),
        .flags    (alu_flags)
    );

    assign alu_zero = alu_flags[flag_z];

    // loads write memory data back, everything else the alu result
    assign reg_wr_data = (result_src == res_src_read_data) ? read_data : alu_out;

endmodule

`default_nettype wire

/* design/riscv_core.sv */
`default_nettype none

module riscv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [riscv_pkg::xlen-1:0] imem_addr,
    input  logic [riscv_pkg::xlen-1:0] imem_rdata,
    output logic [riscv_pkg::xlen-1:0] dmem_addr,
    output logic [riscv_pkg::xlen-1:0] dmem_wdata,
    output logic                       dmem_we,
    input  logic [riscv_pkg::xlen-1:0] dmem_rdata
);
    import riscv_pkg::*;

    // decoded controls running from the control unit to the datapath
    logic                  reg_we;
    logic [imm_src_w-1:0]  imm_src;
    logic [alu_ctrl_w-1:0] alu_ctrl;
    logic                  alu_src;
    logic                  result_src;
    logic                  pc_src;
    logic                  alu_zero;

    // ########################################
    // decode
    // ########################################

    // the store enable goes straight to the data memory port
    control_unit u_control_unit (
        .instr      (imem_rdata),
        .alu_zero   (alu_zero),
        .reg_we     (reg_we),
        .mem_we     (dmem_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src)
    );

    // ########################################
    // execute
    // ########################################

    // the alu result doubles as the data memory address
    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (imem_rdata),
        .read_data  (dmem_rdata),
        .reg_we     (reg_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src),
        .pc         (imem_addr),
        .alu_out    (dmem_addr),
        .write_data (dmem_wdata),
        .alu_zero   (alu_zero)
    );

endmodule

`default_nettype wire

/* verif/tb_memory.sv */
`default_nettype none

module tb_memory (
    input  logic        clk,
    input  logic [31:0] imem_addr,
    output logic [31:0] imem_rdata,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    input  logic        dmem_we,
    output logic [31:0] dmem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // 256 words each, so byte addresses 0x000 to 0x3ff are backed
    localparam int depth = 256;
    // addi x0, x0, 0
    localparam logic [31:0] nop_word = 32'h0000_0013;

    logic [31:0] rom [depth];
    logic [31:0] ram [depth];

    // ########################################
    // program loading
    // ########################################

    // every word outside a loaded program is a nop, so the core
    // just walks on by 4 once it runs off the end
    task automatic clear_rom();
        for (int i = 0; i < depth; i++) begin
            rom[i[7:0]] = nop_word;
        end
    endtask

    task automatic write_rom(input int index, input logic [31:0] word);
        rom[index[7:0]] = word;
    endtask

    // ram starts out holding its own byte address in the low half
    // so a load from the wrong word is easy to spot
    initial begin
        clear_rom();
        for (int i = 0; i < depth; i++) begin
            ram[i[7:0]] = 32'hc0de_0000 | (i << 2);
        end
    end

    // ########################################
    // memory ports
    // ########################################

    // fetches beyond the rom see nops instead of aliased words
    assign imem_rdata = (imem_addr[31:10] == '0) ? rom[imem_addr[9:2]] : nop_word;

    // loads are combinational and stores land at the retiring edge
    assign dmem_rdata = ram[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_riscv_core.sv */
`default_nettype none

module tb_riscv_core;
    timeunit 1ns;
    timeprecision 1ps;

    // ########################################
    // run constants
    // ########################################

    localparam int rng_seed        = 32'h6d07;
    localparam int clk_period      = 20;
    localparam int reset_cycles    = 8;
    localparam int drive_delay     = 2;
    localparam int random_programs = 20;

    // cycles each program runs after reset, the tail executes nops
    localparam int arith_len   = 18;
    localparam int x0_len      = 8;
    localparam int mem_len     = 18;
    localparam int branch_len  = 24;
    localparam int random_len  = 20;
    localparam int illegal_len = 10;
    // every run also spends the reset cycles and one cycle to start
    localparam int run_count    = 5 + random_programs;
    localparam int total_cycles = arith_len + x0_len + mem_len + branch_len
        + random_programs * random_len + illegal_len + run_count * (reset_cycles + 2);
    localparam int watchdog_ns  = total_cycles * clk_period + 2000;

    localparam int op_add = 0;
    localparam int op_sub = 1;
    localparam int op_and = 2;
    localparam int op_or  = 3;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    // expected and observed stores and fetch addresses of one program
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [31:0] exp_trace[$];
    logic [31:0] got_addr[$];
    logic [31:0] got_data[$];
    logic [31:0] got_trace[$];

    // architectural state as the software model sees it
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    int          prog_len;
    int          tests_run;
    int          tests_failed;
    int          error_count;

    riscv_core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    tb_memory u_mem (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ########################################
    // instruction encoders
    // ########################################

    function automatic logic [31:0] i_type_word(input int imm, input int rs1,
                                                input logic [2:0] funct3, input int rd,
                                                input logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    // sw only, so funct3 and opcode are fixed
    function automatic logic [31:0] s_type_word(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // beq only, the offset counts bytes from the branch itself
    function automatic logic [31:0] b_type_word(input int imm, input int rs2, input int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input int rs2,
                                                input int rs1, input logic [2:0] funct3,
                                                input int rd);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] sign_extend_12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    // ########################################
    // program builder and software model
    // ########################################

    task automatic put_word(input logic [31:0] word);
        u_mem.write_rom(prog_len, word);
        prog_len++;
    endtask

    // x0 ignores every write
    task automatic write_model(input int rd, input logic [31:0] value);
        if (rd[4:0] != 5'd0) begin
            model_regs[rd[4:0]] = value;
        end
    endtask

    task automatic addi_instr(input int rd, input int rs1, input int imm);
        put_word(i_type_word(imm, rs1, 3'b000, rd, 7'b0010011));
        write_model(rd, model_regs[rs1[4:0]] + sign_extend_12(imm));
    endtask

    // results wrap at 32 bits like the hardware
    task automatic reg_op_instr(input int op, input int rd, input int rs1, input int rs2);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[rs1[4:0]];
        b = model_regs[rs2[4:0]];
        case (op)
            op_sub: begin
                put_word(r_type_word(7'b0100000, rs2, rs1, 3'b000, rd));
                write_model(rd, a - b);
            end
            op_and: begin
                put_word(r_type_word(7'b0000000, rs2, rs1, 3'b111, rd));
                write_model(rd, a & b);
            end
            op_or: begin
                put_word(r_type_word(7'b0000000, rs2, rs1, 3'b110, rd));
                write_model(rd, a | b);
            end
            default: begin
                put_word(r_type_word(7'b0000000, rs2, rs1, 3'b000, rd));
                write_model(rd, a + b);
            end
        endcase
    endtask

    // a store the model expects to see on the data port
    task automatic store_instr(input int rs2, input int rs1, input int imm);
        logic [31:0] addr;
        addr = model_regs[rs1[4:0]] + sign_extend_12(imm);
        put_word(s_type_word(imm, rs2, rs1));
        exp_addr.push_back(addr);
        exp_data.push_back(model_regs[rs2[4:0]]);
        model_mem[addr[9:2]] = model_regs[rs2[4:0]];
    endtask

    task automatic load_instr(input int rd, input int rs1, input int imm);
        logic [31:0] addr;
        addr = model_regs[rs1[4:0]] + sign_extend_12(imm);
        put_word(i_type_word(imm, rs1, 3'b010, rd, 7'b0000011));
        write_model(rd, model_mem[addr[9:2]]);
    endtask

    // ########################################
    // run and compare
    // ########################################

    // the core sits in reset while the rom is rewritten
    task automatic start_program();
        @(posedge clk);
        #drive_delay;
        rst_n = 1'b0;
        u_mem.clear_rom();
        exp_addr.delete();
        exp_data.delete();
        exp_trace.delete();
        got_addr.delete();
        got_data.delete();
        got_trace.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i[4:0]] = '0;
        end
        prog_len = 0;
        // the nop at address 0 keeps dmem_we low during reset
        addi_instr(0, 0, 0);
    endtask

    // outputs settle well before the falling edge, so sample there
    task automatic run_program(input int cycles);
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            got_trace.push_back(imem_addr);
            if (dmem_we) begin
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
            end
        end
    endtask

    task automatic check_results(input string name, output int errs);
        errs = 0;
        if (got_addr.size() != exp_addr.size()) begin
            $display("%s: the core made %0d stores where %0d were expected",
                     name, got_addr.size(), exp_addr.size());
            errs++;
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (got_addr[i] !== exp_addr[i]) begin
                    $display("** Error %s: store %0d address expected %h actual %h",
                             name, i, exp_addr[i], got_addr[i]);
                    errs++;
                end
                if (got_data[i] !== exp_data[i]) begin
                    $display("** Error %s: store %0d data expected %h actual %h",
                             name, i, exp_data[i], got_data[i]);
                    errs++;
                end
            end
        end
        // fetch order is only checked where a test lays it out
        if (exp_trace.size() != 0) begin
            if (got_trace.size() != exp_trace.size()) begin
                $display("%s: %0d fetches recorded where %0d were expected",
                         name, got_trace.size(), exp_trace.size());
                errs++;
            end else begin
                for (int i = 0; i < exp_trace.size(); i++) begin
                    if (got_trace[i] !== exp_trace[i]) begin
                        $display("** Error %s: fetch %0d address expected %h actual %h",
                                 name, i, exp_trace[i], got_trace[i]);
                        errs++;
                    end
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        error_count += errs;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, errs);
        end
    endtask

    // ########################################
    // directed tests
    // ########################################

    task automatic arith_test();
        int errs;
        start_program();
        addi_instr(1, 0, 100);
        addi_instr(2, 0, -7);
        addi_instr(3, 1, 2047);
        reg_op_instr(op_add, 4, 1, 2);
        // 0xfff9 minus 0x863 goes negative
        reg_op_instr(op_sub, 5, 2, 3);
        reg_op_instr(op_and, 6, 3, 2);
        reg_op_instr(op_or, 7, 1, 2);
        store_instr(3, 0, 64);
        store_instr(4, 0, 68);
        store_instr(5, 0, 72);
        store_instr(6, 0, 76);
        store_instr(7, 0, 80);
        run_program(arith_len);
        check_results("arith", errs);
        finish_test("arith", errs);
    endtask

    task automatic x0_test();
        int errs;
        start_program();
        addi_instr(0, 0, 291);
        addi_instr(1, 0, 58);
        reg_op_instr(op_add, 0, 1, 1);
        store_instr(0, 0, 128);
        store_instr(1, 0, 132);
        run_program(x0_len);
        check_results("x0", errs);
        finish_test("x0", errs);
    endtask

    // stores through a base register, reloads, then stores the copies elsewhere
    task automatic mem_test();
        int errs;
        start_program();
        addi_instr(1, 0, 1445);
        addi_instr(2, 0, -300);
        reg_op_instr(op_add, 3, 1, 2);
        addi_instr(8, 0, 256);
        store_instr(1, 8, 0);
        store_instr(2, 8, 4);
        store_instr(3, 8, 12);
        load_instr(10, 8, 0);
        load_instr(11, 8, 4);
        load_instr(12, 8, 12);
        store_instr(10, 0, 384);
        store_instr(11, 0, 388);
        store_instr(12, 8, 140);
        run_program(mem_len);
        check_results("mem", errs);
        finish_test("mem", errs);
    endtask

    task automatic branch_test();
        int errs;
        start_program();
        addi_instr(1, 0, 5);
        addi_instr(2, 0, 5);
        addi_instr(3, 0, 7);
        // 16: equal operands, jumps over the store at 20
        put_word(b_type_word(8, 2, 1));
        put_word(s_type_word(256, 3, 0));
        // 24: unequal operands fall through to the store at 28
        put_word(b_type_word(8, 3, 1));
        store_instr(3, 0, 260);
        addi_instr(4, 0, 0);
        addi_instr(5, 0, 3);
        // 40 to 48 count x4 up to x5, with the backward beq at 48
        put_word(i_type_word(1, 4, 3'b000, 4, 7'b0010011));
        put_word(b_type_word(8, 5, 4));
        put_word(b_type_word(-8, 0, 0));
        model_regs[4] = 32'd3;
        store_instr(4, 0, 264);
        for (int a = 0; a <= 16; a += 4) begin
            exp_trace.push_back(a);
        end
        for (int a = 24; a <= 36; a += 4) begin
            exp_trace.push_back(a);
        end
        // two full passes, then the exit from the third
        for (int k = 0; k < 3; k++) begin
            exp_trace.push_back(32'd40);
            exp_trace.push_back(32'd44);
            if (k < 2) begin
                exp_trace.push_back(32'd48);
            end
        end
        exp_trace.push_back(32'd52);
        while (exp_trace.size() < branch_len) begin
            exp_trace.push_back(exp_trace[$] + 32'd4);
        end
        run_program(branch_len);
        check_results("branch", errs);
        finish_test("branch", errs);
    endtask

    task automatic random_test();
        int          errs;
        int          sum_errs;
        int unsigned r;
        int          rs1;
        int          rs2;
        sum_errs = 0;
        for (int p = 0; p < random_programs; p++) begin
            start_program();
            for (int k = 1; k <= 4; k++) begin
                r = $urandom;
                addi_instr(k, 0, int'(r));
            end
            // each operation may use any register written so far
            for (int k = 0; k < 6; k++) begin
                r = $urandom;
                rs1 = 1 + int'(r % (4 + k));
                r = $urandom;
                rs2 = 1 + int'(r % (4 + k));
                r = $urandom;
                reg_op_instr(int'(r % 4), 5 + k, rs1, rs2);
                store_instr(5 + k, 0, 768 + 4 * k);
            end
            run_program(random_len);
            check_results($sformatf("random %0d", p), errs);
            sum_errs += errs;
        end
        finish_test("random", sum_errs);
    endtask

    task automatic illegal_test();
        int errs;
        start_program();
        addi_instr(1, 0, 85);
        addi_instr(4, 0, 17);
        store_instr(1, 0, 512);
        // custom-0 opcode carrying the fields of addi x4, x1, 2047
        put_word(i_type_word(2047, 1, 3'b000, 4, 7'b0001011));
        // a sw with one opcode bit flipped must not reach memory
        put_word(s_type_word(520, 1, 0) ^ 32'h0000_0004);
        store_instr(4, 0, 516);
        for (int a = 0; a < illegal_len; a++) begin
            exp_trace.push_back(32'(4 * a));
        end
        run_program(illegal_len);
        check_results("illegal", errs);
        finish_test("illegal", errs);
    endtask

    // ########################################
    // main sequence and watchdog
    // ########################################

    initial begin
        rst_n = 1'b0;
        prog_len = 0;
        tests_run = 0;
        tests_failed = 0;
        error_count = 0;
        void'($urandom(rng_seed));
        arith_test();
        x0_test();
        mem_test();
        branch_test();
        random_test();
        illegal_test();
        $display("tests run %0d, failed %0d, mismatches %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/riscv_pkg.sv
design/regfile.sv
design/imm_extend.sv
design/alu.sv
design/control_unit.sv
design/datapath.sv
design/riscv_core.sv
verif/tb_memory.sv
verif/tb_riscv_core.sv

/* Makefile */
TOP := tb_riscv_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "^No errors$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
